// File: hist_pkg.sv
package hist_pkg;

    // time-bin code, 16 bins
    localparam int BIN_W   = 4;
    // pixel index, up to 4 pixels
    localparam int PIX_W   = 2;
    // bin counter, saturates at 15
    localparam int COUNT_W = 4;
    // bank bit, then pixel, then bin
    localparam int ADDR_W  = 1 + PIX_W + BIN_W;

    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [PIX_W-1:0]   pix_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [ADDR_W-1:0]  mem_addr_t;

    // builder FSM
    // one read-modify-write per event, handoff at frame end
    typedef enum logic [2:0] {
        BLD_IDLE,
        BLD_READ,
        BLD_WAIT,
        BLD_WRITE,
        BLD_HANDOFF
    } builder_state_t;

    // readout FSM
    // read, present on the stream, then write zero back
    typedef enum logic [2:0] {
        RDO_IDLE,
        RDO_READ,
        RDO_WAIT,
        RDO_EMIT,
        RDO_CLEAR
    } readout_state_t;

endpackage

// File: hist_mem_if.sv
`timescale 1ns/1ps

interface hist_mem_if import hist_pkg::*; ();

    // request side, driven by the client
    logic      req;
    logic      we;
    mem_addr_t addr;
    count_t    wdata;

    // response side, driven by the arbiter
    logic      gnt;
    logic      rvalid;
    count_t    rdata;

    // holds req and fields until gnt
    modport client (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    // grant same cycle, rvalid one cycle after a granted read
    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

// File: hist_ram.sv
`timescale 1ns/1ps

module hist_ram import hist_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      en,
    input  logic      we,
    input  mem_addr_t addr,
    input  count_t    wdata,
    output count_t    rdata
);

    // two banks of pixels x bins
    localparam int DEPTH = 2 ** ADDR_W;

    count_t mem [DEPTH];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // whole array starts at zero so both banks are clean
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                // registered read, data one cycle after access
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: hist_arbiter.sv
`timescale 1ns/1ps

module hist_arbiter import hist_pkg::*; (
    input  logic       clk,
    input  logic       res,
    hist_mem_if.arbiter bld,
    hist_mem_if.arbiter rdo,
    output logic       ram_en,
    output logic       ram_we,
    output mem_addr_t  ram_addr,
    output count_t     ram_wdata,
    input  count_t     ram_rdata
);

    // 0 = builder granted last, 1 = readout granted last
    logic last_gnt;
    // read issued last cycle and which client owns it
    logic rd_pend;
    logic rd_owner;
    logic gnt_bld;
    logic gnt_rdo;

    // on contention favour the client not granted last
    assign gnt_bld = bld.req && (!rdo.req || last_gnt);
    assign gnt_rdo = rdo.req && (!bld.req || !last_gnt);

    assign bld.gnt = gnt_bld;
    assign rdo.gnt = gnt_rdo;

    // granted client drives the RAM port
    assign ram_en    = gnt_bld || gnt_rdo;
    assign ram_we    = gnt_rdo ? rdo.we    : bld.we;
    assign ram_addr  = gnt_rdo ? rdo.addr  : bld.addr;
    assign ram_wdata = gnt_rdo ? rdo.wdata : bld.wdata;

    // read data goes back only to its owner
    assign bld.rvalid = rd_pend && !rd_owner;
    assign rdo.rvalid = rd_pend && rd_owner;
    assign bld.rdata  = ram_rdata;
    assign rdo.rdata  = ram_rdata;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            last_gnt <= 1'b1;
            rd_pend  <= 1'b0;
            rd_owner <= 1'b0;
        end else begin
            if (ram_en) begin
                last_gnt <= gnt_rdo;
            end
            // track the read for the data cycle
            rd_pend  <= ram_en && !ram_we;
            rd_owner <= gnt_rdo;
        end
    end

endmodule

// File: hist_builder.sv
`timescale 1ns/1ps

module hist_builder import hist_pkg::*; #(
    parameter int PIXEL_NUM        = 4,
    parameter int EVENTS_PER_PIXEL = 8,
    parameter int ACQ_NUM          = 2
) (
    input  logic       clk,
    input  logic       res,
    input  logic       ev_valid,
    output logic       ev_ready,
    input  bin_t       ev_bin,
    hist_mem_if.client mem,
    output logic       frame_valid,
    input  logic       frame_ready
);

    localparam int EV_W  = (EVENTS_PER_PIXEL > 1) ? $clog2(EVENTS_PER_PIXEL) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    builder_state_t   state;
    // event within pixel, pixel, acquisition
    logic [EV_W-1:0]  ev_cnt;
    pix_t             pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    // bank being filled
    logic             bank;
    bin_t             bin_q;
    count_t           cnt_q;
    logic             ev_wrap;
    logic             pix_wrap;
    logic             acq_wrap;

    assign ev_wrap  = (ev_cnt == EV_W'(EVENTS_PER_PIXEL - 1));
    assign pix_wrap = (pix_cnt == pix_t'(PIXEL_NUM - 1));
    assign acq_wrap = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    assign ev_ready    = (state == BLD_IDLE);
    assign frame_valid = (state == BLD_HANDOFF);

    // same address for the read and the write back
    assign mem.req   = (state == BLD_READ) || (state == BLD_WRITE);
    assign mem.we    = (state == BLD_WRITE);
    assign mem.addr  = {bank, pix_cnt, bin_q};
    assign mem.wdata = cnt_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= BLD_IDLE;
            ev_cnt  <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
            bank    <= 1'b0;
        end else begin
            case (state)
                BLD_IDLE: begin
                    if (ev_valid) begin
                        state <= BLD_READ;
                    end
                end
                BLD_READ: begin
                    if (mem.gnt) begin
                        state <= BLD_WAIT;
                    end
                end
                BLD_WAIT: begin
                    if (mem.rvalid) begin
                        state <= BLD_WRITE;
                    end
                end
                BLD_WRITE: begin
                    if (mem.gnt) begin
                        // nested counters advance once the write lands
                        state  <= BLD_IDLE;
                        ev_cnt <= ev_wrap ? '0 : ev_cnt + 1'b1;
                        if (ev_wrap) begin
                            pix_cnt <= pix_wrap ? '0 : pix_cnt + 1'b1;
                            if (pix_wrap) begin
                                acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
                                if (acq_wrap) begin
                                    state <= BLD_HANDOFF;
                                end
                            end
                        end
                    end
                end
                BLD_HANDOFF: begin
                    // readout idle, swap banks
                    if (frame_ready) begin
                        bank  <= ~bank;
                        state <= BLD_IDLE;
                    end
                end
                default: state <= BLD_IDLE;
            endcase
        end
    end

    // captured bin and incremented count
    always_ff @(posedge clk) begin
        if (ev_valid && ev_ready) begin
            bin_q <= ev_bin;
        end
        if (state == BLD_WAIT && mem.rvalid) begin
            // saturate at all ones
            cnt_q <= (mem.rdata == '1) ? mem.rdata : mem.rdata + 1'b1;
        end
    end

endmodule

// File: hist_readout.sv
`timescale 1ns/1ps

module hist_readout import hist_pkg::*; #(
    parameter int PIXEL_NUM = 4
) (
    input  logic       clk,
    input  logic       res,
    input  logic       frame_valid,
    output logic       frame_ready,
    hist_mem_if.client mem,
    output logic       out_valid,
    input  logic       out_ready,
    output pix_t       out_pixel,
    output bin_t       out_bin,
    output count_t     out_count,
    output logic       out_last
);

    readout_state_t state;
    // sweep pointers
    pix_t           pix_ptr;
    bin_t           bin_ptr;
    // bank being drained, flips after each sweep
    logic           bank;
    count_t         count_q;
    logic           last_word;

    assign last_word = (pix_ptr == pix_t'(PIXEL_NUM - 1)) && (bin_ptr == '1);

    assign frame_ready = (state == RDO_IDLE);

    // read then clear the same word
    assign mem.req   = (state == RDO_READ) || (state == RDO_CLEAR);
    assign mem.we    = (state == RDO_CLEAR);
    assign mem.addr  = {bank, pix_ptr, bin_ptr};
    assign mem.wdata = '0;

    // stream held stable through EMIT
    assign out_valid = (state == RDO_EMIT);
    assign out_pixel = pix_ptr;
    assign out_bin   = bin_ptr;
    assign out_count = count_q;
    assign out_last  = last_word;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= RDO_IDLE;
            pix_ptr <= '0;
            bin_ptr <= '0;
            bank    <= 1'b0;
        end else begin
            case (state)
                RDO_IDLE: begin
                    if (frame_valid) begin
                        pix_ptr <= '0;
                        bin_ptr <= '0;
                        state   <= RDO_READ;
                    end
                end
                RDO_READ: begin
                    if (mem.gnt) begin
                        state <= RDO_WAIT;
                    end
                end
                RDO_WAIT: begin
                    if (mem.rvalid) begin
                        state <= RDO_EMIT;
                    end
                end
                RDO_EMIT: begin
                    if (out_ready) begin
                        state <= RDO_CLEAR;
                    end
                end
                RDO_CLEAR: begin
                    if (mem.gnt) begin
                        if (last_word) begin
                            // bank clean, next frame uses the other one
                            bank  <= ~bank;
                            state <= RDO_IDLE;
                        end else begin
                            // bins ascending within pixel
                            bin_ptr <= bin_ptr + 1'b1;
                            if (bin_ptr == '1) begin
                                pix_ptr <= pix_ptr + 1'b1;
                            end
                            state <= RDO_READ;
                        end
                    end
                end
                default: state <= RDO_IDLE;
            endcase
        end
    end

    // word under presentation
    always_ff @(posedge clk) begin
        if (state == RDO_WAIT && mem.rvalid) begin
            count_q <= mem.rdata;
        end
    end

endmodule

// File: hist_top.sv
`timescale 1ns/1ps

module hist_top import hist_pkg::*; #(
    parameter int PIXEL_NUM        = 4,
    parameter int EVENTS_PER_PIXEL = 8,
    parameter int ACQ_NUM          = 2
) (
    input  logic   clk,
    input  logic   res,
    // event stream
    input  logic   ev_valid,
    output logic   ev_ready,
    input  bin_t   ev_bin,
    // histogram stream
    output logic   out_valid,
    input  logic   out_ready,
    output pix_t   out_pixel,
    output bin_t   out_bin,
    output count_t out_count,
    output logic   out_last
);

    // frame handoff
    logic      frame_valid;
    logic      frame_ready;
    // shared RAM port
    logic      ram_en;
    logic      ram_we;
    mem_addr_t ram_addr;
    count_t    ram_wdata;
    count_t    ram_rdata;

    hist_mem_if bld_mem ();
    hist_mem_if rdo_mem ();

    hist_builder #(
        .PIXEL_NUM        (PIXEL_NUM),
        .EVENTS_PER_PIXEL (EVENTS_PER_PIXEL),
        .ACQ_NUM          (ACQ_NUM)
    ) u_builder (
        .clk         (clk),
        .res         (res),
        .ev_valid    (ev_valid),
        .ev_ready    (ev_ready),
        .ev_bin      (ev_bin),
        .mem         (bld_mem),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready)
    );

    hist_readout #(
        .PIXEL_NUM (PIXEL_NUM)
    ) u_readout (
        .clk         (clk),
        .res         (res),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .mem         (rdo_mem),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_pixel   (out_pixel),
        .out_bin     (out_bin),
        .out_count   (out_count),
        .out_last    (out_last)
    );

    hist_arbiter u_arbiter (
        .clk       (clk),
        .res       (res),
        .bld       (bld_mem),
        .rdo       (rdo_mem),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    hist_ram u_ram (
        .clk   (clk),
        .res   (res),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// File: hist_checker.sv
`timescale 1ns/1ps

module hist_checker (
    input logic clk,
    input logic res,
    input logic bld_req,
    input logic bld_we,
    input logic bld_gnt,
    input logic bld_rvalid,
    input logic rdo_req,
    input logic rdo_we,
    input logic rdo_gnt,
    input logic rdo_rvalid
);

    // single-port RAM, one owner per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!res)
        !(bld_gnt && rdo_gnt))
        else $error("both clients granted in one cycle");

    // no grant without a request
    a_bld_gnt_req: assert property (@(posedge clk) disable iff (!res)
        bld_gnt |-> bld_req)
        else $error("builder granted without request");

    a_rdo_gnt_req: assert property (@(posedge clk) disable iff (!res)
        rdo_gnt |-> rdo_req)
        else $error("readout granted without request");

    // read data exactly one cycle after a granted read
    a_bld_rvalid: assert property (@(posedge clk) disable iff (!res)
        bld_rvalid |-> $past(bld_gnt && !bld_we))
        else $error("builder rvalid without a granted read");

    a_rdo_rvalid: assert property (@(posedge clk) disable iff (!res)
        rdo_rvalid |-> $past(rdo_gnt && !rdo_we))
        else $error("readout rvalid without a granted read");

endmodule

bind hist_arbiter hist_checker u_checker (
    .clk        (clk),
    .res        (res),
    .bld_req    (bld.req),
    .bld_we     (bld.we),
    .bld_gnt    (bld.gnt),
    .bld_rvalid (bld.rvalid),
    .rdo_req    (rdo.req),
    .rdo_we     (rdo.we),
    .rdo_gnt    (rdo.gnt),
    .rdo_rvalid (rdo.rvalid)
);

// File: hist_tb.sv
`timescale 1ns/1ps

module hist_tb import hist_pkg::*; ();

    localparam int PIXEL_NUM        = 4;
    localparam int EVENTS_PER_PIXEL = 8;
    localparam int ACQ_NUM          = 2;
    localparam int EV_PER_FRAME     = PIXEL_NUM * EVENTS_PER_PIXEL * ACQ_NUM;
    localparam int WORDS_PER_FRAME  = PIXEL_NUM * 16;
    localparam int TOTAL_FRAMES     = 10;
    localparam real CLK_PERIOD      = 8.0;

    logic   clk;
    logic   res;
    logic   ev_valid;
    logic   ev_ready;
    bin_t   ev_bin;
    logic   out_valid;
    logic   out_ready;
    pix_t   out_pixel;
    bin_t   out_bin;
    count_t out_count;
    logic   out_last;

    // pending events and expected words {last, pixel, bin, count}
    bin_t        ev_q [$];
    logic [10:0] exp_q [$];
    logic [10:0] prev_word;
    logic        prev_pending;
    string       cur_test;
    int          err_count;
    int          check_count;
    int          test_count;

    hist_top #(
        .PIXEL_NUM        (PIXEL_NUM),
        .EVENTS_PER_PIXEL (EVENTS_PER_PIXEL),
        .ACQ_NUM          (ACQ_NUM)
    ) DUT (
        .clk       (clk),
        .res       (res),
        .ev_valid  (ev_valid),
        .ev_ready  (ev_ready),
        .ev_bin    (ev_bin),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel),
        .out_bin   (out_bin),
        .out_count (out_count),
        .out_last  (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // budget of frames x (events + words) x 8 cycles
    initial begin
        #(TOTAL_FRAMES * (EV_PER_FRAME + WORDS_PER_FRAME) * 8 * CLK_PERIOD);
        $display("watchdog expired, the histogram stream did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_value(input string what, input int exp, input int act);
        check_count++;
        if (exp != act) begin
            err_count++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    // reference histogram for one frame
    // EVENTS_PER_PIXEL events per pixel in turn for each acquisition
    task automatic build_frame(input bit one_bin);
        int   hist [PIXEL_NUM][16];
        bin_t fixed;
        bin_t b;
        int   pix;
        fixed = bin_t'($urandom_range(15));
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int bb = 0; bb < 16; bb++) begin
                hist[p][bb] = 0;
            end
        end
        for (int k = 0; k < EV_PER_FRAME; k++) begin
            b   = one_bin ? fixed : bin_t'($urandom_range(15));
            pix = (k / EVENTS_PER_PIXEL) % PIXEL_NUM;
            // saturating counter
            if (hist[pix][b] < 15) begin
                hist[pix][b]++;
            end
            ev_q.push_back(b);
        end
        // pixel-major with bins ascending and the last flag on the final word
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int bb = 0; bb < 16; bb++) begin
                exp_q.push_back({(p == PIXEL_NUM - 1) && (bb == 15), pix_t'(p), bin_t'(bb),
                                 count_t'(hist[p][bb])});
            end
        end
    endtask

    // one event per handshake with optional idle gaps
    task automatic send_events(input int gap_pct);
        bit done;
        while (ev_q.size() > 0) begin
            if ($urandom_range(99) < gap_pct) begin
                ev_valid = 1'b0;
                repeat ($urandom_range(3, 1)) @(posedge clk);
                #1;
            end
            ev_valid = 1'b1;
            ev_bin   = ev_q.pop_front();
            done     = 1'b0;
            while (!done) begin
                @(negedge clk);
                done = ev_ready;
                @(posedge clk);
                #1;
            end
        end
        ev_valid = 1'b0;
    endtask

    // sampled mid-cycle so the transfer lands on the next rising edge
    task automatic check_word();
        logic [10:0] exp;
        if (out_valid) begin
            if (prev_pending && {out_last, out_pixel, out_bin, out_count} != prev_word) begin
                err_count++;
                $display("[FAIL] %s held word: expected %h, actual %h", cur_test, prev_word,
                         {out_last, out_pixel, out_bin, out_count});
            end
            prev_word    = {out_last, out_pixel, out_bin, out_count};
            prev_pending = !out_ready;
            if (out_ready) begin
                exp = exp_q.pop_front();
                check_value("pixel", int'(exp[9:8]), int'(out_pixel));
                check_value("bin", int'(exp[7:4]), int'(out_bin));
                check_value("count", int'(exp[3:0]), int'(out_count));
                check_value("last", int'(exp[10]), int'(out_last));
            end
        end else begin
            if (prev_pending) begin
                err_count++;
                $display("%s: out_valid dropped before the word was accepted", cur_test);
            end
            prev_pending = 1'b0;
        end
    endtask

    // out_ready held low for hold cycles and random after that
    task automatic drain_output(input int stall_pct, input int hold);
        int held;
        held = 0;
        while (exp_q.size() > 0) begin
            if (held < hold) begin
                out_ready = 1'b0;
                held++;
            end else begin
                out_ready = ($urandom_range(99) >= stall_pct);
            end
            @(negedge clk);
            check_word();
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
    endtask

    task automatic run_test(input string name, input int frames, input bit one_bin,
                            input int gap_pct, input int stall_pct, input int hold);
        int errs_before;
        cur_test    = name;
        errs_before = err_count;
        for (int f = 0; f < frames; f++) begin
            build_frame(one_bin);
        end
        fork
            send_events(gap_pct);
            drain_output(stall_pct, hold);
        join
        test_count++;
        $display("test %s: %0d frames, %0d errors", name, frames, err_count - errs_before);
    endtask

    initial begin
        void'($urandom(32'he06ab95c));
        err_count    = 0;
        check_count  = 0;
        test_count   = 0;
        prev_pending = 1'b0;
        prev_word    = '0;
        res          = 1'b0;
        ev_valid     = 1'b0;
        ev_bin       = '0;
        out_ready    = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        res = 1'b1;
        @(posedge clk);
        #1;
        run_test("single_frame", 1, 1'b0, 0, 0, 0);
        run_test("random_gaps", 2, 1'b0, 30, 30, 0);
        run_test("back_to_back", 3, 1'b0, 0, 0, 0);
        run_test("word_order", 1, 1'b0, 10, 40, 0);
        run_test("saturation", 1, 1'b1, 0, 0, 0);
        // long stall while two frames queue up behind the readout
        run_test("back_pressure", 2, 1'b0, 0, 20, 600);
        // nothing may follow the last frame
        cur_test  = "trailing";
        out_ready = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (out_valid) begin
                err_count++;
                $display("%s: unexpected output word after the last frame", cur_test);
            end
        end
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hist_pkg.sv
hist_mem_if.sv
hist_ram.sv
hist_arbiter.sv
hist_builder.sv
hist_readout.sv
hist_top.sv
hist_checker.sv
hist_tb.sv

// File: Makefile
# Verilator build and run for the histogram subsystem

VERILATOR ?= verilator
TOP       ?= hist_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# fails on a nonzero exit or on the fail message in the log
run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
